/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_csr_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
rtl/csr_pkg.sv
rtl/csr_mode_regs.sv
rtl/csr_int_ctrl.sv
rtl/csr_exc_regs.sv
rtl/csr_timer.sv
rtl/csr_read_mux.sv
rtl/csr_top.sv
verif/csr_checks.sv
verif/tb_csr_top.sv

/* rtl/csr_exc_regs.sv */
`timescale 1ns/100ps

module csr_exc_regs import csr_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_wr_t                wr,
    input  exc_req_t               exc,
    output logic [14:0]            estat_code,
    output logic [CSR_W-1:0]       era,
    output logic [CSR_W-1:0]       eentry,
    output logic [3:0][CSR_W-1:0]  save_img
);

    logic [5:0]       ecode;
    logic [8:0]       subcode;
    logic [25:0]      eentry_va;
    logic [CSR_W-1:0] estat_wr;
    logic [CSR_W-1:0] era_wr;
    logic [CSR_W-1:0] eentry_wr;

    assign estat_code = {subcode, ecode};
    assign eentry     = {eentry_va, 6'b0};

    // code fields sit at ESTAT 30..16
    assign estat_wr  = masked_wr({1'b0, subcode, ecode, 16'b0}, wr.mask, wr.data);
    assign era_wr    = masked_wr(era, wr.mask, wr.data);
    assign eentry_wr = masked_wr(eentry, wr.mask, wr.data);

    //////////////////////////////////////////////////
    // ESTAT code, ERA, EENTRY
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecode   <= 6'b0;
            subcode <= 9'b0;
        end else if (exc.ecode_we) begin
            ecode <= exc.ecode_in[5:0];
            // interrupts (code 0) carry no sub-code
            subcode <= (|exc.ecode_in[5:0]) ? 9'(exc.ecode_in[6]) : 9'b0;
        end else if (wr.en && wr.addr == CSR_ESTAT) begin
            ecode   <= estat_wr[21:16];
            subcode <= estat_wr[30:22];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            era <= '0;
        end else if (exc.era_we) begin
            era <= exc.era_in;
        end else if (wr.en && wr.addr == CSR_ERA) begin
            era <= era_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            eentry_va <= '0;
        end else if (wr.en && wr.addr == CSR_EENTRY) begin
            eentry_va <= eentry_wr[31:6];
        end
    end

    //////////////////////////////////////////////////
    // SAVE0..3
    //////////////////////////////////////////////////

    for (genvar i = 0; i < 4; i++) begin : g_save
        localparam logic [13:0] SAVE_ADDR = 14'(CSR_SAVE0) + 14'(i);

        always_ff @(posedge clk) begin
            if (!rstn) begin
                save_img[i] <= '0;
            end else if (wr.en && wr.addr == SAVE_ADDR) begin
                save_img[i] <= masked_wr(save_img[i], wr.mask, wr.data);
            end
        end
    end

endmodule

/* rtl/csr_int_ctrl.sv */
`timescale 1ns/100ps

module csr_int_ctrl import csr_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  csr_wr_t             wr,
    input  logic [HW_INT_N-1:0] hardware_int,
    input  logic                timer_int,
    input  logic                crmd_ie,
    output logic [IS_W-1:0]     is_vec,
    output logic [CSR_W-1:0]    ecfg_img,
    output logic                has_interrupt_cpu,
    output logic                has_interrupt_idle
);

    logic [IS_W-1:0]  lie;
    logic [1:0]       swi;
    logic [CSR_W-1:0] ecfg_wr;
    logic [CSR_W-1:0] swi_wr;

    assign ecfg_img = CSR_W'(lie);
    assign ecfg_wr  = masked_wr(ecfg_img, wr.mask, wr.data);
    assign swi_wr   = masked_wr(CSR_W'(swi), wr.mask, wr.data);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lie <= '0;
            swi <= 2'b0;
        end else if (wr.en) begin
            if (wr.addr == CSR_ECFG) begin
                lie <= ecfg_wr[IS_W-1:0];
            end
            // software interrupts live in ESTAT bits 1..0
            if (wr.addr == CSR_ESTAT) begin
                swi <= swi_wr[1:0];
            end
        end
    end

    // bits 10 and 12 stay 0
    always_comb begin
        is_vec                = '0;
        is_vec[1:0]           = swi;
        is_vec[HW_INT_N+1:2]  = hardware_int;
        is_vec[TI_BIT]        = timer_int;
    end

    assign has_interrupt_idle = |is_vec;
    assign has_interrupt_cpu  = crmd_ie & (|(is_vec & lie));

endmodule

/* rtl/csr_mode_regs.sv */
`timescale 1ns/100ps

module csr_mode_regs import csr_pkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  csr_wr_t          wr,
    input  exc_req_t         exc,
    output crmd_t            crmd,
    output logic [CSR_W-1:0] prmd_img
);

    logic [1:0]       pplv;
    logic             pie;
    logic [CSR_W-1:0] crmd_wr;
    logic [CSR_W-1:0] prmd_wr;
    logic [1:0]       pair_next;

    // masked images as software would leave them
    assign crmd_wr   = masked_wr(CSR_W'(crmd), wr.mask, wr.data);
    assign prmd_wr   = masked_wr(prmd_img, wr.mask, wr.data);
    assign pair_next = crmd_wr[4:3];

    assign prmd_img = {29'b0, pie, pplv};

    //////////////////////////////////////////////////
    // CRMD
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd.plv  <= 2'b0;
            crmd.ie   <= 1'b0;
            crmd.mode <= TM_DIRECT;
        end else if (exc.restore_state) begin
            crmd.plv <= pplv;
            crmd.ie  <= pie;
        end else if (exc.store_state) begin
            crmd.plv <= 2'b0;
            crmd.ie  <= 1'b0;
        end else if (wr.en && wr.addr == CSR_CRMD) begin
            crmd.plv <= crmd_wr[1:0];
            crmd.ie  <= crmd_wr[2];
            // illegal pg/da pair keeps the old mode
            if (pair_next inside {TM_DIRECT, TM_PAGED}) begin
                crmd.mode <= trans_mode_e'(pair_next);
            end
        end
    end

    //////////////////////////////////////////////////
    // PRMD
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pplv <= 2'b0;
            pie  <= 1'b0;
        end else if (exc.store_state) begin
            pplv <= crmd.plv;
            pie  <= crmd.ie;
        end else if (wr.en && wr.addr == CSR_PRMD) begin
            pplv <= prmd_wr[1:0];
            pie  <= prmd_wr[2];
        end
    end

endmodule

/* rtl/csr_pkg.sv */
package csr_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int CSR_W    = 32;
    localparam int HW_INT_N = 8;
    localparam int IS_W     = 13;
    // timer interrupt position in IS
    localparam int TI_BIT   = 11;

    //////////////////////////////////////////////////
    // register numbers
    //////////////////////////////////////////////////

    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    // {pg, da}, only one-hot pairs are legal
    typedef enum logic [1:0] {
        TM_DIRECT = 2'b01,
        TM_PAGED  = 2'b10
    } trans_mode_e;

    //////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                en;
        csr_addr_e           addr;
        logic [CSR_W-1:0]    mask;
        logic [CSR_W-1:0]    data;
    } csr_wr_t;

    typedef struct packed {
        logic                store_state;
        logic                restore_state;
        logic                ecode_we;
        // [5:0] primary code, [6] sub-code
        logic [6:0]          ecode_in;
        logic                era_we;
        logic [CSR_W-1:0]    era_in;
    } exc_req_t;

    // CRMD bits 4..0
    typedef struct packed {
        trans_mode_e         mode;
        logic                ie;
        logic [1:0]          plv;
    } crmd_t;

    // per-bit masked update of a register image
    function automatic logic [CSR_W-1:0] masked_wr(
        input logic [CSR_W-1:0] old_val,
        input logic [CSR_W-1:0] mask,
        input logic [CSR_W-1:0] data
    );
        return (old_val & ~mask) | (data & mask);
    endfunction

endpackage

/* rtl/csr_read_mux.sv */
`timescale 1ns/100ps

module csr_read_mux import csr_pkg::*; #(
    parameter int TIMER_W = 32
) (
    input  csr_addr_e              raddr_a,
    input  csr_addr_e              raddr_b,
    input  crmd_t                  crmd,
    input  logic [CSR_W-1:0]       prmd_img,
    input  logic [CSR_W-1:0]       ecfg_img,
    input  logic [IS_W-1:0]        is_vec,
    input  logic [14:0]            estat_code,
    input  logic [CSR_W-1:0]       era,
    input  logic [CSR_W-1:0]       eentry,
    input  logic [3:0][CSR_W-1:0]  save_img,
    input  logic [CSR_W-1:0]       tcfg_img,
    input  logic [TIMER_W-1:0]     tval,
    output logic [CSR_W-1:0]       rdata_a,
    output logic [CSR_W-1:0]       rdata_b
);

    logic [CSR_W-1:0] estat_img;
    csr_addr_e        raddr [2];
    logic [CSR_W-1:0] rdata [2];

    // subcode 30..22, ecode 21..16, IS 12..0
    assign estat_img = {1'b0, estat_code[14:6], estat_code[5:0], 3'b0, is_vec};

    assign raddr[0] = raddr_a;
    assign raddr[1] = raddr_b;

    for (genvar p = 0; p < 2; p++) begin : g_port
        always_comb begin
            case (raddr[p])
                CSR_CRMD:   rdata[p] = CSR_W'(crmd);
                CSR_PRMD:   rdata[p] = prmd_img;
                CSR_ECFG:   rdata[p] = ecfg_img;
                CSR_ESTAT:  rdata[p] = estat_img;
                CSR_ERA:    rdata[p] = era;
                CSR_EENTRY: rdata[p] = eentry;
                CSR_SAVE0:  rdata[p] = save_img[0];
                CSR_SAVE1:  rdata[p] = save_img[1];
                CSR_SAVE2:  rdata[p] = save_img[2];
                CSR_SAVE3:  rdata[p] = save_img[3];
                CSR_TCFG:   rdata[p] = tcfg_img;
                CSR_TVAL:   rdata[p] = CSR_W'(tval);
                // TICLR and unknown numbers
                default:    rdata[p] = '0;
            endcase
        end
    end

    assign rdata_a = rdata[0];
    assign rdata_b = rdata[1];

endmodule

/* rtl/csr_timer.sv */
`timescale 1ns/100ps

module csr_timer import csr_pkg::*; #(
    parameter int TIMER_W = 32
) (
    input  logic               clk,
    input  logic               rstn,
    input  csr_wr_t            wr,
    output logic [CSR_W-1:0]   tcfg_img,
    output logic [TIMER_W-1:0] tval,
    output logic               timer_int
);

    logic             en;
    logic             periodic;
    logic [29:0]      initval;
    logic             just_set;
    logic             time_out;
    logic             tcfg_hit;
    logic             ticlr_hit;
    logic [CSR_W-1:0] tcfg_wr;
    logic [CSR_W-1:0] reload;

    assign tcfg_img  = {initval, periodic, en};
    assign tcfg_hit  = wr.en && wr.addr == CSR_TCFG;
    assign ticlr_hit = wr.en && wr.addr == CSR_TICLR && wr.mask[0] && wr.data[0];
    assign tcfg_wr   = masked_wr(tcfg_img, wr.mask, wr.data);
    // low bits forced to 01 so an initval of 0 still fires
    assign reload    = {initval, 2'b01};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= '0;
            just_set <= 1'b0;
        end else begin
            if (tcfg_hit) begin
                en       <= tcfg_wr[0];
                periodic <= tcfg_wr[1];
                initval  <= tcfg_wr[31:2];
            end
            just_set <= tcfg_hit && (|wr.mask);
        end
    end

    //////////////////////////////////////////////////
    // countdown
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else if (just_set || tval == '0) begin
            time_out <= 1'b0;
            // one-shot holds at zero
            if (just_set || (en && periodic)) begin
                tval <= reload[TIMER_W-1:0];
            end
        end else if (en) begin
            tval     <= tval - 1'b1;
            time_out <= (tval == TIMER_W'(1));
        end else begin
            time_out <= 1'b0;
        end
    end

    // sticky until TICLR
    always_ff @(posedge clk) begin
        if (!rstn) begin
            timer_int <= 1'b0;
        end else if (ticlr_hit) begin
            timer_int <= 1'b0;
        end else if (time_out) begin
            timer_int <= 1'b1;
        end
    end

endmodule

/* rtl/csr_top.sv */
`timescale 1ns/100ps

module csr_top import csr_pkg::*; #(
    parameter int TIMER_W = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  csr_wr_t             wr,
    input  exc_req_t            exc,
    input  csr_addr_e           raddr_a,
    input  csr_addr_e           raddr_b,
    input  logic [HW_INT_N-1:0] hardware_int,
    output logic [CSR_W-1:0]    rdata_a,
    output logic [CSR_W-1:0]    rdata_b,
    output logic [1:0]          plv,
    output logic [5:0]          ecode,
    output logic [CSR_W-1:0]    era_out,
    output logic [CSR_W-1:0]    eentry,
    output logic                has_interrupt_cpu,
    output logic                has_interrupt_idle,
    output trans_mode_e         translate_mode
);

    crmd_t                  crmd;
    logic [CSR_W-1:0]       prmd_img;
    logic [IS_W-1:0]        is_vec;
    logic [CSR_W-1:0]       ecfg_img;
    logic [14:0]            estat_code;
    logic [3:0][CSR_W-1:0]  save_img;
    logic [CSR_W-1:0]       tcfg_img;
    logic [TIMER_W-1:0]     tval;
    logic                   timer_int;

    csr_mode_regs mode_i (
        .clk      (clk),
        .rstn     (rstn),
        .wr       (wr),
        .exc      (exc),
        .crmd     (crmd),
        .prmd_img (prmd_img)
    );

    csr_int_ctrl int_i (
        .clk                (clk),
        .rstn               (rstn),
        .wr                 (wr),
        .hardware_int       (hardware_int),
        .timer_int          (timer_int),
        .crmd_ie            (crmd.ie),
        .is_vec             (is_vec),
        .ecfg_img           (ecfg_img),
        .has_interrupt_cpu  (has_interrupt_cpu),
        .has_interrupt_idle (has_interrupt_idle)
    );

    csr_exc_regs exc_i (
        .clk        (clk),
        .rstn       (rstn),
        .wr         (wr),
        .exc        (exc),
        .estat_code (estat_code),
        .era        (era_out),
        .eentry     (eentry),
        .save_img   (save_img)
    );

    csr_timer #(
        .TIMER_W (TIMER_W)
    ) timer_i (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr),
        .tcfg_img  (tcfg_img),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_read_mux #(
        .TIMER_W (TIMER_W)
    ) rmux_i (
        .raddr_a    (raddr_a),
        .raddr_b    (raddr_b),
        .crmd       (crmd),
        .prmd_img   (prmd_img),
        .ecfg_img   (ecfg_img),
        .is_vec     (is_vec),
        .estat_code (estat_code),
        .era        (era_out),
        .eentry     (eentry),
        .save_img   (save_img),
        .tcfg_img   (tcfg_img),
        .tval       (tval),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b)
    );

    assign plv            = crmd.plv;
    assign translate_mode = crmd.mode;
    assign ecode          = estat_code[5:0];

endmodule

/* verif/csr_checks.sv */
`timescale 1ns/100ps

module csr_checks import csr_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  csr_wr_t             wr,
    input  exc_req_t            exc,
    input  csr_addr_e           raddr_a,
    input  csr_addr_e           raddr_b,
    input  logic [HW_INT_N-1:0] hardware_int,
    input  logic [CSR_W-1:0]    rdata_a,
    input  logic [CSR_W-1:0]    rdata_b,
    input  logic [1:0]          plv,
    input  logic [5:0]          ecode,
    input  logic [CSR_W-1:0]    era_out,
    input  logic [CSR_W-1:0]    eentry,
    input  logic                has_interrupt_cpu,
    input  logic                has_interrupt_idle,
    input  trans_mode_e         translate_mode,
    output logic                check_fail
);

    logic [1:0]  m_plv, m_pplv, m_mode, m_swi;
    logic        m_ie, m_pie;
    logic [12:0] m_lie;
    logic [5:0]  m_ecode;
    logic [8:0]  m_sub;
    logic [31:0] m_era, m_eentry, m_tcfg;
    logic [31:0] m_save [4];
    logic        fail_rd, fail_out, fail_cpu, fail_idle;

    assign check_fail = fail_rd | fail_out | fail_cpu | fail_idle;

    function automatic logic [31:0] upd(logic [31:0] old_val);
        return (old_val & ~wr.mask) | (wr.data & wr.mask);
    endfunction

    function automatic logic [31:0] model_read(csr_addr_e a);
        case (a)
            CSR_CRMD:   return {27'b0, m_mode, m_ie, m_plv};
            CSR_PRMD:   return {29'b0, m_pie, m_pplv};
            CSR_ECFG:   return {19'b0, m_lie};
            CSR_ESTAT:  return {1'b0, m_sub, m_ecode, 6'b0, hardware_int, m_swi};
            CSR_ERA:    return m_era;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0:  return m_save[0];
            CSR_SAVE1:  return m_save[1];
            CSR_SAVE2:  return m_save[2];
            CSR_SAVE3:  return m_save[3];
            CSR_TCFG:   return m_tcfg;
            default:    return 32'b0;
        endcase
    endfunction

    // timer bit and TVAL are checked by the stimulus
    function automatic logic [31:0] care(csr_addr_e a);
        if (a == CSR_TVAL) begin
            return 32'b0;
        end
        return (a == CSR_ESTAT) ? 32'hffff_f7ff : 32'hffff_ffff;
    endfunction

    //////////////////////////////////////////////////
    // register model
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [31:0] cw;
        logic [31:0] pw;
        logic [31:0] ew;
        logic [31:0] sw;
        logic [31:0] lw;
        cw = upd({27'b0, m_mode, m_ie, m_plv});
        pw = upd({29'b0, m_pie, m_pplv});
        ew = upd({1'b0, m_sub, m_ecode, 16'b0});
        sw = upd({30'b0, m_swi});
        lw = upd({19'b0, m_lie});
        if (!rstn) begin
            m_plv    <= 2'b0;
            m_ie     <= 1'b0;
            m_mode   <= 2'b01;
            m_pplv   <= 2'b0;
            m_pie    <= 1'b0;
            m_swi    <= 2'b0;
            m_lie    <= '0;
            m_ecode  <= '0;
            m_sub    <= '0;
            m_era    <= '0;
            m_eentry <= '0;
            m_tcfg   <= '0;
            m_save   <= '{default: 32'b0};
        end else begin
            if (exc.restore_state) begin
                m_plv <= m_pplv;
                m_ie  <= m_pie;
            end else if (exc.store_state) begin
                m_plv <= 2'b0;
                m_ie  <= 1'b0;
            end else if (wr.en && wr.addr == CSR_CRMD) begin
                m_plv <= cw[1:0];
                m_ie  <= cw[2];
                if (cw[4:3] == 2'b01 || cw[4:3] == 2'b10) begin
                    m_mode <= cw[4:3];
                end
            end
            if (exc.store_state) begin
                m_pplv <= m_plv;
                m_pie  <= m_ie;
            end else if (wr.en && wr.addr == CSR_PRMD) begin
                {m_pie, m_pplv} <= pw[2:0];
            end
            if (exc.ecode_we) begin
                m_ecode <= exc.ecode_in[5:0];
                m_sub   <= (exc.ecode_in[5:0] != 6'b0) ? {8'b0, exc.ecode_in[6]} : 9'b0;
            end else if (wr.en && wr.addr == CSR_ESTAT) begin
                {m_sub, m_ecode} <= ew[30:16];
            end
            if (wr.en && wr.addr == CSR_ESTAT) m_swi <= sw[1:0];
            if (exc.era_we) begin
                m_era <= exc.era_in;
            end else if (wr.en && wr.addr == CSR_ERA) begin
                m_era <= upd(m_era);
            end
            if (wr.en && wr.addr == CSR_ECFG) m_lie <= lw[12:0];
            if (wr.en && wr.addr == CSR_EENTRY) m_eentry <= upd(m_eentry) & 32'hffff_ffc0;
            if (wr.en && wr.addr == CSR_TCFG) m_tcfg <= upd(m_tcfg);
            if (wr.en && wr.addr == CSR_SAVE0) m_save[0] <= upd(m_save[0]);
            if (wr.en && wr.addr == CSR_SAVE1) m_save[1] <= upd(m_save[1]);
            if (wr.en && wr.addr == CSR_SAVE2) m_save[2] <= upd(m_save[2]);
            if (wr.en && wr.addr == CSR_SAVE3) m_save[3] <= upd(m_save[3]);
        end
    end

    //////////////////////////////////////////////////
    // read ports against the model
    //////////////////////////////////////////////////

    initial begin
        fail_rd   = 1'b0;
        fail_out  = 1'b0;
        fail_cpu  = 1'b0;
        fail_idle = 1'b0;
    end

    always @(posedge clk) begin
        if (rstn) begin
            assert ((rdata_a & care(raddr_a)) == (model_read(raddr_a) & care(raddr_a)))
            else begin
                $display("mismatch at %0t: rdata_a got %h expected %h", $time, rdata_a,
                         model_read(raddr_a));
                fail_rd = 1'b1;
            end
            assert ((rdata_b & care(raddr_b)) == (model_read(raddr_b) & care(raddr_b)))
            else begin
                $display("mismatch at %0t: rdata_b got %h expected %h", $time, rdata_b,
                         model_read(raddr_b));
                fail_rd = 1'b1;
            end
        end
    end

    // output ports follow the stored state
    assert property (@(posedge clk) disable iff (!rstn)
        plv == m_plv && translate_mode == m_mode && ecode == m_ecode &&
        era_out == m_era && eentry == m_eentry)
    else begin
        $write("mismatch at %0t: plv/translate_mode/ecode/era_out/eentry got %h %h %h %h %h",
               $time, plv, translate_mode, ecode, era_out, eentry);
        $display(" expected %h %h %h %h %h", m_plv, m_mode, m_ecode, m_era, m_eentry);
        fail_out = 1'b1;
    end

    // pending outputs against the IS bits seen on port a
    assert property (@(posedge clk) disable iff (!rstn)
        raddr_a == CSR_ESTAT |->
            has_interrupt_cpu == (m_ie && (|(rdata_a[IS_W-1:0] & m_lie))))
    else begin
        $display("mismatch at %0t: has_interrupt_cpu got %b expected %b", $time,
                 has_interrupt_cpu, m_ie && (|(rdata_a[IS_W-1:0] & m_lie)));
        fail_cpu = 1'b1;
    end

    assert property (@(posedge clk) disable iff (!rstn)
        raddr_a == CSR_ESTAT |-> has_interrupt_idle == (|rdata_a[IS_W-1:0]))
    else begin
        $display("mismatch at %0t: has_interrupt_idle got %b expected %b", $time,
                 has_interrupt_idle, |rdata_a[IS_W-1:0]);
        fail_idle = 1'b1;
    end

endmodule

/* verif/tb_csr_top.sv */
`timescale 1ns/100ps

module tb_csr_top import csr_pkg::*; ();

    logic                clk;
    logic                rstn;
    csr_wr_t             wr;
    exc_req_t            exc;
    csr_addr_e           raddr_a, raddr_b;
    logic [HW_INT_N-1:0] hardware_int;
    logic [CSR_W-1:0]    rdata_a, rdata_b, era_out, eentry;
    logic [1:0]          plv;
    logic [5:0]          ecode;
    logic                has_interrupt_cpu, has_interrupt_idle, check_fail;
    trans_mode_e         translate_mode;
    logic [31:0]         v0, v1, v2;
    logic [2:0]          idx;
    csr_addr_e           rw_addrs [7];

    csr_top dut_i (.*);

    csr_checks checks_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic expect_eq(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic csr_write(csr_addr_e a, logic [31:0] m, logic [31:0] d);
        @(negedge clk);
        wr = '{en: 1'b1, addr: a, mask: m, data: d};
        @(negedge clk);
        wr.en = 1'b0;
    endtask

    task automatic read_a(csr_addr_e a, output logic [31:0] v);
        @(negedge clk);
        raddr_a = a;
        @(negedge clk);
        v = rdata_a;
    endtask

    task automatic exc_pulse(exc_req_t r);
        @(negedge clk);
        exc = r;
        @(negedge clk);
        exc = '0;
    endtask

    task automatic wait_idle(logic level, int max_cycles);
        int n;
        n = 0;
        while (has_interrupt_idle !== level) begin
            if (n >= max_cycles) begin
                fail_run("has_interrupt_idle did not reach the expected level in time");
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    always @(posedge check_fail) fail_run("a register or output check failed");

    initial begin
        void'($urandom(32'h2700_dc27));
        rw_addrs = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA, CSR_EENTRY, CSR_ECFG};
        rstn = 1'b0;
        wr = '0;
        exc = '0;
        raddr_a = CSR_CRMD;
        raddr_b = CSR_PRMD;
        hardware_int = '0;
        repeat (10) @(negedge clk);
        rstn = 1'b1;

        //////////////////////////////////////////////////
        // reset values and masked writes
        //////////////////////////////////////////////////
        read_a(CSR_CRMD, v0);
        expect_eq("crmd", v0, 32'h8);
        expect_eq("translate_mode", 32'(translate_mode), 32'(TM_DIRECT));
        expect_eq("interrupts", {30'b0, has_interrupt_cpu, has_interrupt_idle}, 32'b0);
        for (int i = 0; i < 7; i++) begin
            @(negedge clk);
            raddr_a = rw_addrs[i];
            raddr_b = rw_addrs[6 - i];
        end
        for (int i = 0; i < 24; i++) begin
            idx = 3'($urandom_range(6));
            csr_write(rw_addrs[idx], $urandom, $urandom);
            raddr_a = rw_addrs[idx];
            raddr_b = rw_addrs[3'($urandom_range(6))];
            @(negedge clk);
        end
        raddr_a = csr_addr_e'(14'h007);
        raddr_b = CSR_TICLR;
        @(negedge clk);
        expect_eq("rdata_a unknown", rdata_a, 32'b0);
        expect_eq("rdata_b ticlr", rdata_b, 32'b0);

        // illegal pg/da pairs keep the old mode
        csr_write(CSR_CRMD, 32'h18, 32'h18);
        expect_eq("translate_mode", 32'(translate_mode), 32'(TM_DIRECT));
        csr_write(CSR_CRMD, 32'h18, 32'h10);
        expect_eq("translate_mode", 32'(translate_mode), 32'(TM_PAGED));
        csr_write(CSR_CRMD, 32'h18, 32'h00);
        expect_eq("translate_mode", 32'(translate_mode), 32'(TM_PAGED));
        csr_write(CSR_CRMD, 32'h18, 32'h08);
        expect_eq("translate_mode", 32'(translate_mode), 32'(TM_DIRECT));

        //////////////////////////////////////////////////
        // exception entry and return
        //////////////////////////////////////////////////
        csr_write(CSR_CRMD, 32'h7, 32'h7);
        exc_pulse('{store_state: 1'b1, default: '0});
        expect_eq("plv", 32'(plv), 32'h0);
        read_a(CSR_PRMD, v0);
        expect_eq("prmd", v0, 32'h7);
        exc_pulse('{restore_state: 1'b1, default: '0});
        expect_eq("plv", 32'(plv), 32'h3);
        exc_pulse('{ecode_we: 1'b1, ecode_in: 7'h4b, default: '0});
        read_a(CSR_ESTAT, v0);
        expect_eq("estat code", {17'b0, v0[30:16]}, 32'h4b);
        exc_pulse('{ecode_we: 1'b1, ecode_in: 7'h40, default: '0});
        expect_eq("ecode", 32'(ecode), 32'h0);
        @(negedge clk);
        wr = '{en: 1'b1, addr: CSR_ERA, mask: 32'hffff_ffff, data: 32'h1111_2222};
        exc = '{era_we: 1'b1, era_in: 32'h8000_1c40, default: '0};
        @(negedge clk);
        wr.en = 1'b0;
        exc = '0;
        expect_eq("era_out", era_out, 32'h8000_1c40);

        //////////////////////////////////////////////////
        // interrupts
        //////////////////////////////////////////////////
        csr_write(CSR_ECFG, 32'hffff_ffff, 32'h0);
        hardware_int = 8'h04;
        @(negedge clk);
        expect_eq("idle/cpu", {30'b0, has_interrupt_idle, has_interrupt_cpu}, 32'h2);
        read_a(CSR_ESTAT, v0);
        expect_eq("estat is", {24'b0, v0[9:2]}, 32'h04);
        csr_write(CSR_ECFG, 32'hffff_ffff, 32'h10);
        expect_eq("has_interrupt_cpu", 32'(has_interrupt_cpu), 32'h1);
        csr_write(CSR_CRMD, 32'h4, 32'h0);
        expect_eq("has_interrupt_cpu", 32'(has_interrupt_cpu), 32'h0);
        hardware_int = 8'h00;
        @(negedge clk);

        //////////////////////////////////////////////////
        // timer
        //////////////////////////////////////////////////
        csr_write(CSR_TCFG, 32'hffff_ffff, {30'd4, 2'b01});
        repeat (2) @(negedge clk);
        read_a(CSR_TVAL, v0);
        read_a(CSR_TVAL, v1);
        read_a(CSR_TVAL, v2);
        if (!(v1 < v0 && v2 < v1)) begin
            fail_run("TVAL did not count down after the TCFG write");
        end
        wait_idle(1'b1, 100);
        repeat (5) @(negedge clk);
        read_a(CSR_ESTAT, v0);
        expect_eq("estat timer bit", 32'(v0[TI_BIT]), 32'h1);
        expect_eq("has_interrupt_idle", 32'(has_interrupt_idle), 32'h1);
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        expect_eq("has_interrupt_idle", 32'(has_interrupt_idle), 32'h0);
        read_a(CSR_ESTAT, v0);
        expect_eq("estat timer bit", 32'(v0[TI_BIT]), 32'h0);
        // periodic mode fires again after a clear
        csr_write(CSR_TCFG, 32'hffff_ffff, {30'd1, 2'b11});
        wait_idle(1'b1, 100);
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        expect_eq("has_interrupt_idle", 32'(has_interrupt_idle), 32'h0);
        wait_idle(1'b1, 100);

        repeat (2) @(negedge clk);
        if (check_fail) begin
            fail_run("a check failed before the end of the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
